//--- gem_pkg.sv
`default_nettype none

package gem_pkg;

  // --------------------
  // Frame geometry
  // --------------------

  parameter int unsigned mxclst     = 4;                 // Clusters per received frame
  parameter int unsigned clst_bits  = 14;                // Bits per cluster
  parameter int unsigned frame_bits = mxclst * clst_bits; // 56-bit link word

  parameter int unsigned adr_bits = 11;                  // Strip address field
  parameter int unsigned cnt_bits = clst_bits - adr_bits; // Cluster size count field

  // --------------------
  // Cluster types
  // --------------------

  // One GEM cluster as packed on the link
  // Count sits above the strip address
  typedef struct packed {
    logic [cnt_bits-1:0] cnt; // Number of extra pads in cluster
    logic [adr_bits-1:0] adr; // Strip address, 3 in bits 10:9 marks an empty slot
  } cluster_t;

  // All clusters of one frame, lane 0 in the low bits
  typedef cluster_t [mxclst-1:0] cluster_lanes_t;

  // Lane select for single cluster readout
  typedef logic [$clog2(mxclst)-1:0] lane_sel_t;

  // --------------------
  // Debug capture FSM
  // --------------------

  typedef enum logic [1:0] {
    cap_ready   = 2'd0, // Armed, waiting for a valid cluster
    cap_writing = 2'd1, // Filling the debug RAM
    cap_readout = 2'd2  // Full, held until software rearms
  } capture_state_t;

endpackage

`default_nettype wire

//--- gem_cluster_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded cluster bus from the frame decoder to the buffers
// Level signals, valid on every clock
interface gem_cluster_if import gem_pkg::*; ();

  cluster_lanes_t    cluster; // Four decoded clusters
  logic [mxclst-1:0] vpf;     // Valid pattern flag per lane
  logic [mxclst-1:0] parity;  // Odd parity bit per lane for RAM storage
  logic              any_vpf; // At least one lane holds a hit

  // Decoder side
  modport source (
    output cluster,
    output vpf,
    output parity,
    output any_vpf
  );

  // RAM and capture controller side
  modport sink (
    input cluster,
    input vpf,
    input parity,
    input any_vpf
  );

endinterface

`default_nettype wire

//--- gem_frame_decode.sv
`timescale 1ns/1ps
`default_nettype none

module gem_frame_decode import gem_pkg::*; (
  input  wire logic                  clock,          // System clock
  input  wire logic                  reset,          // Sync reset, active high
  input  wire logic [frame_bits-1:0] gem_frame,      // Link word from optical receiver
  output logic                       gtx_rx_nonzero, // Registered OR of the link word
  gem_cluster_if.source              clusters        // Decoded cluster bus
);

  // --------------------
  // Input register
  // --------------------

  logic [frame_bits-1:0] frame_r;    // Registered link word
  logic                  nonzero_r;  // Any bit set in the link word
  cluster_lanes_t        lanes;      // Registered word viewed as clusters
  logic [mxclst-1:0]     vpf;        // Per lane valid flags
  logic [mxclst-1:0]     parity;     // Per lane odd parity

  always_ff @(posedge clock) begin
    if (reset) begin
      frame_r   <= '0;               // Zero frame after reset
      nonzero_r <= 1'b0;
    end else begin
      frame_r   <= gem_frame;
      nonzero_r <= |gem_frame;       // Flag tracks the same frame as frame_r
    end
  end

  assign lanes = cluster_lanes_t'(frame_r); // Lane 0 is bits 13:0

  // --------------------
  // Per lane decode
  // --------------------

  // An address with both top bits set is the empty-slot marker
  // Parity is the complement of the XOR so an all-zero word stores a one
  for (genvar i = 0; i < mxclst; i++) begin : g_lane
    assign vpf[i]    = ~(lanes[i].adr[adr_bits-1] & lanes[i].adr[adr_bits-2]); // Invalid on 11
    assign parity[i] = ~(^lanes[i]);                                           // Odd parity
  end

  // --------------------
  // Bus outputs
  // --------------------

  assign clusters.cluster = lanes;
  assign clusters.vpf     = vpf;
  assign clusters.parity  = parity;
  assign clusters.any_vpf = |vpf;    // Capture trigger

  assign gtx_rx_nonzero = nonzero_r;

endmodule

`default_nettype wire

//--- gem_hits_ram.sv
`timescale 1ns/1ps
`default_nettype none

// Four lane cluster store, each lane one inferred block RAM
// Word is parity bit above the 14-bit cluster
module gem_hits_ram import gem_pkg::*; #(
  parameter int unsigned ram_adrb = 11          // Address width, depth is 2**ram_adrb
) (
  input  wire logic                clock,       // System clock
  input  wire logic                wen,         // Write enable for all lanes
  input  wire logic [ram_adrb-1:0] wadr,        // Write address
  gem_cluster_if.sink              clusters,    // Write data from decoder
  input  wire logic [ram_adrb-1:0] radr,        // Read address
  output cluster_lanes_t           rdata,       // Registered read clusters
  output logic [mxclst-1:0]        rparity      // Registered stored parity
);

  localparam int unsigned ram_depth = 1 << ram_adrb; // Storage depth in bx
  localparam int unsigned word_bits = clst_bits + 1;  // Cluster plus parity

  // --------------------
  // Lane memories
  // --------------------

  for (genvar i = 0; i < mxclst; i++) begin : g_lane

    logic [word_bits-1:0] mem [ram_depth];   // One RAM per lane
    logic [word_bits-1:0] rd_word;           // Read port register
    logic [word_bits-1:0] wr_word;           // Parity packed above cluster

    assign wr_word = {clusters.parity[i], clusters.cluster[i]};

    // Write port
    always_ff @(posedge clock) begin
      if (wen) begin
        mem[wadr] <= wr_word;
      end
    end

    // Read port, old data on a same-address collision
    always_ff @(posedge clock) begin
      rd_word <= mem[radr];
    end

    assign rdata[i]   = cluster_t'(rd_word[clst_bits-1:0]);
    assign rparity[i] = rd_word[clst_bits]; // Parity bit stored on top

  end

endmodule

`default_nettype wire

//--- gem_capture_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// Fills the debug RAM once after the first valid cluster
// Then holds until rearmed by capture_reset
module gem_capture_ctrl import gem_pkg::*; #(
  parameter int unsigned capture_adrb = 10          // Debug RAM address width
) (
  input  wire logic                    clock,         // System clock
  input  wire logic                    reset,         // Sync reset, active high
  gem_cluster_if.sink                  clusters,      // Decoded bus, trigger source
  input  wire logic                    capture_reset, // Rearm pulse from software
  output logic                         wen,           // Debug RAM write enable
  output logic [capture_adrb-1:0]      wadr           // Debug RAM write address
);

  // --------------------
  // State and counter
  // --------------------

  capture_state_t            state;    // Capture FSM
  logic [capture_adrb-1:0]   adr;      // Write address counter
  logic                      last_adr; // Counter at the top of the RAM

  assign last_adr = &adr;              // All ones ends the capture

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= cap_ready;
      adr   <= '0;
    end else begin
      case (state)
        cap_ready: begin
          adr <= '0;                    // Start from the bottom
          if (clusters.any_vpf) begin
            state <= cap_writing;       // First hit seen
          end
        end
        cap_writing: begin
          adr <= adr + 1'b1;            // One word per bx
          if (last_adr) begin
            state <= cap_readout;       // RAM full
          end
        end
        cap_readout: begin
          if (capture_reset) begin
            state <= cap_ready;         // Rearm
          end
        end
        default: begin
          state <= cap_ready;           // Unused encoding
        end
      endcase
    end
  end

  // --------------------
  // RAM controls
  // --------------------

  assign wen  = (state == cap_writing); // Writes only while filling
  assign wadr = adr;

endmodule

`default_nettype wire

//--- gem_readout.sv
`timescale 1ns/1ps
`default_nettype none

// Single cluster readout from a four lane RAM with parity check
// Adds one register stage after the RAM read register
module gem_readout import gem_pkg::*; (
  input  wire logic                 clock,      // System clock
  input  wire cluster_lanes_t       rdata,      // RAM read clusters
  input  wire logic [mxclst-1:0]    rparity,    // RAM stored parity
  input  wire lane_sel_t            sel,        // Lane to present, with the read address
  output logic [clst_bits-1:0]      lane_data,  // Selected cluster
  output logic [mxclst-1:0]         parity_err  // Stored parity disagrees, per lane
);

  // --------------------
  // Lane select
  // --------------------

  lane_sel_t         sel_r;       // Select delayed to match RAM read
  logic [mxclst-1:0] parity_exp;  // Parity recomputed from read data

  always_ff @(posedge clock) begin
    sel_r     <= sel;             // Same edge as the RAM address
    lane_data <= rdata[sel_r];    // Mux then register
  end

  // --------------------
  // Parity check
  // --------------------

  // Same odd parity rule as the decoder uses on write
  for (genvar i = 0; i < mxclst; i++) begin : g_par
    assign parity_exp[i] = ~(^rdata[i]);
  end

  always_ff @(posedge clock) begin
    parity_err <= rparity ^ parity_exp; // High where stored and recomputed differ
  end

endmodule

`default_nettype wire

//--- gem_top.sv
`timescale 1ns/1ps
`default_nettype none

module gem_top import gem_pkg::*; #(
  parameter int unsigned raw_adrb   = 11,   // Raw hits RAM, 2048 deep
  parameter int unsigned debug_adrb = 10    // Debug capture RAM, 1024 deep
) (
  input  wire logic                   clock,            // System clock
  input  wire logic                   reset,            // Sync reset, active high

  // Link input
  input  wire logic [frame_bits-1:0]  gem_frame,        // 56-bit frame each bx

  // Raw hits RAM
  input  wire logic                   fifo_wen,         // Write enable
  input  wire logic [raw_adrb-1:0]    fifo_wadr,        // Write address
  input  wire logic [raw_adrb-1:0]    fifo_radr,        // Read address
  input  wire lane_sel_t              fifo_sel,         // Read lane 0-3

  // Debug capture RAM
  input  wire logic [debug_adrb-1:0]  debug_fifo_radr,  // Read address
  input  wire lane_sel_t              debug_fifo_sel,   // Read lane 0-3
  input  wire logic                   debug_fifo_reset, // Rearm capture

  // Decoded clusters
  output logic [clst_bits-1:0]        gem_cluster0,
  output logic [clst_bits-1:0]        gem_cluster1,
  output logic [clst_bits-1:0]        gem_cluster2,
  output logic [clst_bits-1:0]        gem_cluster3,
  output logic [mxclst-1:0]           gem_vpf,          // Valid flag per lane
  output logic                        gtx_rx_nonzero,   // Frame had any bit set

  // Readout
  output logic [clst_bits-1:0]        fifo_rdata,       // Raw hits cluster
  output logic [mxclst-1:0]           parity_err_gem,   // Raw hits parity errors
  output logic [clst_bits-1:0]        debug_fifo_rdata, // Debug cluster
  output logic [mxclst-1:0]           debug_parity_err  // Debug parity errors
);

  // --------------------
  // Decoder
  // --------------------

  gem_cluster_if gem_bus ();

  gem_frame_decode u_decode (
    .clock          (clock),
    .reset          (reset),
    .gem_frame      (gem_frame),
    .gtx_rx_nonzero (gtx_rx_nonzero),
    .clusters       (gem_bus.source)
  );

  assign gem_cluster0 = gem_bus.cluster[0];
  assign gem_cluster1 = gem_bus.cluster[1];
  assign gem_cluster2 = gem_bus.cluster[2];
  assign gem_cluster3 = gem_bus.cluster[3];
  assign gem_vpf      = gem_bus.vpf;

  // --------------------
  // Raw hits path
  // --------------------

  cluster_lanes_t    raw_rdata;     // Raw RAM read clusters
  logic [mxclst-1:0] raw_rparity;   // Raw RAM stored parity

  gem_hits_ram #(.ram_adrb(raw_adrb)) u_raw_ram (
    .clock    (clock),
    .wen      (fifo_wen),
    .wadr     (fifo_wadr),
    .clusters (gem_bus.sink),
    .radr     (fifo_radr),
    .rdata    (raw_rdata),
    .rparity  (raw_rparity)
  );

  gem_readout u_raw_readout (
    .clock      (clock),
    .rdata      (raw_rdata),
    .rparity    (raw_rparity),
    .sel        (fifo_sel),
    .lane_data  (fifo_rdata),
    .parity_err (parity_err_gem)
  );

  // --------------------
  // Debug capture path
  // --------------------

  logic                  debug_wen;      // From capture FSM
  logic [debug_adrb-1:0] debug_wadr;     // From capture counter
  cluster_lanes_t        debug_rdata;    // Debug RAM read clusters
  logic [mxclst-1:0]     debug_rparity;  // Debug RAM stored parity

  gem_capture_ctrl #(.capture_adrb(debug_adrb)) u_capture (
    .clock         (clock),
    .reset         (reset),
    .clusters      (gem_bus.sink),
    .capture_reset (debug_fifo_reset),
    .wen           (debug_wen),
    .wadr          (debug_wadr)
  );

  gem_hits_ram #(.ram_adrb(debug_adrb)) u_debug_ram (
    .clock    (clock),
    .wen      (debug_wen),
    .wadr     (debug_wadr),
    .clusters (gem_bus.sink),
    .radr     (debug_fifo_radr),
    .rdata    (debug_rdata),
    .rparity  (debug_rparity)
  );

  gem_readout u_debug_readout (
    .clock      (clock),
    .rdata      (debug_rdata),
    .rparity    (debug_rparity),
    .sel        (debug_fifo_sel),
    .lane_data  (debug_fifo_rdata),
    .parity_err (debug_parity_err)
  );

endmodule

`default_nettype wire

//--- tb_gem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gem import gem_pkg::*; ();

  typedef logic [frame_bits-1:0] frame_t;

  typedef enum int {
    op_decode,   // Decoder outputs only
    op_raw_read, // Also raw hits readout
    op_dbg_read  // Also debug capture readout
  } op_t;

  typedef struct {
    frame_t      frame;  // Link word for this cycle
    logic        wen;    // Raw hits write enable
    logic [10:0] wadr;
    logic [10:0] radr;   // Low 10 bits drive the debug port
    lane_sel_t   sel;    // Lane for both readouts
    logic        dreset; // Capture rearm pulse
    op_t         op;
    int          test;
    logic        chk;    // Read hits written data
    logic [13:0] exp;    // Expected readout cluster
  } step_t;

  localparam int n_tests   = 7;
  localparam int raw_depth = 2048;
  localparam int dbg_depth = 1024;

  // --------------------
  // DUT
  // --------------------

  logic                  clock;
  logic                  reset;
  logic [frame_bits-1:0] gem_frame;
  logic                  fifo_wen;
  logic [10:0]           fifo_wadr;
  logic [10:0]           fifo_radr;
  lane_sel_t             fifo_sel;
  logic [9:0]            debug_fifo_radr;
  lane_sel_t             debug_fifo_sel;
  logic                  debug_fifo_reset;
  logic [clst_bits-1:0]  gem_cluster0;
  logic [clst_bits-1:0]  gem_cluster1;
  logic [clst_bits-1:0]  gem_cluster2;
  logic [clst_bits-1:0]  gem_cluster3;
  logic [mxclst-1:0]     gem_vpf;
  logic                  gtx_rx_nonzero;
  logic [clst_bits-1:0]  fifo_rdata;
  logic [mxclst-1:0]     parity_err_gem;
  logic [clst_bits-1:0]  debug_fifo_rdata;
  logic [mxclst-1:0]     debug_parity_err;

  gem_top uut (.*);

  always #50 clock = ~clock; // 100 ns period

  // --------------------
  // Reference model
  // --------------------

  step_t          steps [$];               // Stimulus table
  frame_t         m_frame;                 // Frame held in the decoder register
  capture_state_t m_state;                 // Expected capture FSM state
  int             m_adr;                   // Expected capture address
  cluster_lanes_t raw_mem [raw_depth];
  bit             raw_written [raw_depth];
  cluster_lanes_t dbg_mem [dbg_depth];
  bit             dbg_written [dbg_depth];
  logic [31:0]    lcg_state;
  int             cur_test;
  string          test_names [n_tests];
  int             test_end [n_tests];      // Last table entry of each test
  int             n_checks [n_tests];
  int             n_errors [n_tests];
  bit             table_ready = 1'b0;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic frame_t rand_frame();
    logic [31:0] hi;
    hi        = lcg_next(lcg_state);
    lcg_state = lcg_next(hi);
    return {hi[31:8], lcg_state};
  endfunction

  // Every lane gets the empty-slot address
  function automatic frame_t invalid_frame(input frame_t f);
    return f | {mxclst{14'h0600}};
  endfunction

  function automatic logic [mxclst-1:0] expected_vpf(input frame_t f);
    cluster_lanes_t    lanes;
    logic [mxclst-1:0] v;
    lanes = f;
    for (int l = 0; l < mxclst; l++) begin
      v[l] = (lanes[l].adr[10:9] != 2'b11); // Both top bits set is an empty slot
    end
    return v;
  endfunction

  task automatic add_step(input frame_t frame, input op_t op, input int radr, input int sel,
                          input logic wen, input int wadr, input logic dreset);
    step_t s;
    s.frame  = frame;
    s.wen    = wen;
    s.wadr   = 11'(wadr);
    s.radr   = 11'(radr);
    s.sel    = lane_sel_t'(sel);
    s.dreset = dreset;
    s.op     = op;
    s.test   = cur_test;
    s.chk    = 1'b0;
    s.exp    = '0;
    steps.push_back(s);
    test_end[cur_test] = steps.size() - 1;
  endtask

  // Advances the model over the edge that samples entry i
  task automatic step_model(input int i);
    step_t s;
    s = steps[i];
    if (s.op == op_raw_read) begin
      steps[i].chk = raw_written[s.radr];
      steps[i].exp = raw_mem[s.radr][s.sel];         // Old data if written this edge
    end else if (s.op == op_dbg_read) begin
      steps[i].chk = dbg_written[s.radr[9:0]];
      steps[i].exp = dbg_mem[s.radr[9:0]][s.sel];
    end
    if (s.wen) begin
      raw_mem[s.wadr]     = m_frame;                 // Frame already in the decoder
      raw_written[s.wadr] = 1'b1;
    end
    case (m_state)
      cap_ready: begin
        if (expected_vpf(m_frame) != '0) begin
          m_state = cap_writing;                     // Any valid lane arms the fill
          m_adr   = 0;
        end
      end
      cap_writing: begin
        dbg_mem[m_adr]     = m_frame;
        dbg_written[m_adr] = 1'b1;
        if (m_adr == dbg_depth - 1) begin
          m_state = cap_readout;                     // Top word written
        end
        m_adr = m_adr + 1;
      end
      default: begin
        if (s.dreset) begin
          m_state = cap_ready;
        end
      end
    endcase
    m_frame = s.frame;
  endtask

  task automatic apply_step(input int i);
    gem_frame        = steps[i].frame;
    fifo_wen         = steps[i].wen;
    fifo_wadr        = steps[i].wadr;
    fifo_radr        = steps[i].radr;
    fifo_sel         = steps[i].sel;
    debug_fifo_radr  = steps[i].radr[9:0];
    debug_fifo_sel   = steps[i].sel;
    debug_fifo_reset = steps[i].dreset;
    step_model(i);
  endtask

  // --------------------
  // Checks and reports
  // --------------------

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act,
                             input int t);
    n_checks[t]++;
    assert (act === exp) else begin
      $display("MISMATCH %s at %0t: expected %h, got %h", name, $time, exp, act);
      n_errors[t]++;
    end
  endtask

  // Decode of entry i and the read sampled one edge earlier
  task automatic run_checks(input int i);
    cluster_lanes_t lanes;
    step_t          r;
    int             t;
    if (i < steps.size()) begin
      lanes = steps[i].frame;
      t     = steps[i].test;
      check_value("gem_cluster0", lanes[0], gem_cluster0, t);
      check_value("gem_cluster1", lanes[1], gem_cluster1, t);
      check_value("gem_cluster2", lanes[2], gem_cluster2, t);
      check_value("gem_cluster3", lanes[3], gem_cluster3, t);
      check_value("gem_vpf", expected_vpf(steps[i].frame), gem_vpf, t);
      check_value("gtx_rx_nonzero", |steps[i].frame, gtx_rx_nonzero, t);
    end
    if (i > 0 && steps[i-1].chk) begin
      r = steps[i-1];
      if (r.op == op_raw_read) begin
        check_value("fifo_rdata", r.exp, fifo_rdata, r.test);
        check_value("parity_err_gem", '0, parity_err_gem, r.test);
      end else begin
        check_value("debug_fifo_rdata", r.exp, debug_fifo_rdata, r.test);
        check_value("debug_parity_err", '0, debug_parity_err, r.test);
      end
    end
  endtask

  task automatic report_tests(input int i);
    for (int t = 0; t < n_tests; t++) begin
      if (test_end[t] + 1 == i) begin
        $display("test %s: %0d checks, %0d errors, capture %s",
                 test_names[t], n_checks[t], n_errors[t], m_state.name());
      end
    end
  endtask

  // --------------------
  // Stimulus table
  // --------------------

  task automatic build_table();
    frame_t      f;
    logic [10:0] raw_adr [6];
    logic [10:0] dbg_adr [7];
    raw_adr    = '{11'd0, 11'd2047, 11'd5, 11'd1000, 11'd1024, 11'd1};
    dbg_adr    = '{11'd0, 11'd1, 11'd2, 11'd100, 11'd511, 11'd1022, 11'd1023};
    test_names = '{"decode", "raw_store", "capture_fill", "capture_hold",
                   "capture_trigger", "capture_burst", "capture_rearm"};
    cur_test = 0;
    add_step('0, op_decode, 0, 0, 0, 0, 0);                  // Zero frame, all lanes valid
    add_step({frame_bits{1'b1}}, op_decode, 0, 0, 0, 0, 0);  // All lanes empty
    add_step({mxclst{14'h0600}}, op_decode, 0, 0, 0, 0, 0);  // Bare empty markers
    add_step({14'h0600, 14'h0400, 14'h0200, 14'h3fff}, op_decode, 0, 0, 0, 0, 0);
    add_step(56'h1, op_decode, 0, 0, 0, 0, 0);
    for (int k = 0; k < 7; k++) begin
      add_step(rand_frame(), op_decode, 0, 0, 0, 0, 0);
    end
    cur_test = 1;                                           // Each write stores the previous frame
    for (int k = 0; k < 6; k++) begin
      add_step(rand_frame(), op_decode, 0, 0, 1'b1, raw_adr[k], 0);
    end
    for (int k = 0; k < 24; k++) begin
      add_step(rand_frame(), op_raw_read, raw_adr[k / 4], k % 4, 0, 0, 0);
    end
    cur_test = 2;                                           // Capture runs from reset release
    for (int k = 0; k < 1000; k++) begin
      add_step(rand_frame(), op_decode, 0, 0, 0, 0, 0);
    end
    for (int k = 0; k < 28; k++) begin
      add_step(rand_frame(), op_dbg_read, dbg_adr[k / 4], k % 4, 0, 0, 0);
    end
    cur_test = 3;                                           // Full RAM ignores new hits
    for (int k = 0; k < 20; k++) begin
      add_step(rand_frame(), op_decode, 0, 0, 0, 0, 0);
    end
    for (int k = 0; k < 8; k++) begin
      add_step(rand_frame(), op_dbg_read, (k % 2) * 1023, k / 2, 0, 0, 0);
    end
    cur_test = 4;                                           // Rearmed, empty frames only
    for (int k = 0; k < 27; k++) begin
      add_step(invalid_frame(rand_frame()), op_decode, 0, 0, 0, 0, k == 3);
    end
    for (int k = 0; k < 4; k++) begin
      add_step(invalid_frame(rand_frame()), op_dbg_read, 0, k, 0, 0, 0);
    end
    cur_test = 5;
    f     = invalid_frame(rand_frame());
    f[10] = 1'b0;                                           // Lane 0 address becomes valid
    add_step(f, op_decode, 0, 0, 0, 0, 0);
    for (int k = 0; k < 1030; k++) begin
      add_step(rand_frame(), op_decode, 0, 0, 0, 0, 0);
    end
    for (int k = 0; k < 28; k++) begin
      add_step(rand_frame(), op_dbg_read, dbg_adr[k / 4], k % 4, 0, 0, 0);
    end
    cur_test = 6;                                           // Hold, then second rearm
    for (int k = 0; k < 9; k++) begin
      add_step(rand_frame(), (k > 4) ? op_dbg_read : op_decode, 0, k % 4, 0, 0, 0);
    end
    for (int k = 0; k < 5; k++) begin
      add_step(invalid_frame(rand_frame()), op_decode, 0, 0, 0, 0, k == 2);
    end
    add_step(f, op_decode, 0, 0, 0, 0, 0);
    for (int k = 0; k < 16; k++) begin
      add_step(rand_frame(), (k > 7) ? op_dbg_read : op_decode, k % 2, k / 2, 0, 0, 0);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    int total_checks;
    int total_errors;
    clock            = 1'b0;
    reset            = 1'b1;
    gem_frame        = '0;
    fifo_wen         = 1'b0;
    fifo_wadr        = '0;
    fifo_radr        = '0;
    fifo_sel         = '0;
    debug_fifo_radr  = '0;
    debug_fifo_sel   = '0;
    debug_fifo_reset = 1'b0;
    m_frame          = '0;                       // Decoder register after reset
    m_state          = cap_ready;
    m_adr            = 0;
    lcg_state        = 32'hef20_c350;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clock);
    #5;
    reset = 1'b0;
    for (int i = 0; i <= steps.size(); i++) begin
      if (i < steps.size()) begin
        apply_step(i);                           // 5 ns after the edge
      end
      @(posedge clock);
      #5;
      run_checks(i);
      report_tests(i);
    end
    total_checks = 0;
    total_errors = 0;
    for (int t = 0; t < n_tests; t++) begin
      total_checks += n_checks[t];
      total_errors += n_errors[t];
    end
    $display("%0d tests, %0d checks, %0d errors", n_tests, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Twice the expected run length
  initial begin
    longint limit_ns;
    wait (table_ready);
    limit_ns = (longint'(steps.size()) + 1100 + 16) * 100 * 2;
    #(limit_ns);
    $display("Timeout: the run did not complete within %0d ns", limit_ns);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
gem_pkg.sv
gem_cluster_if.sv
gem_frame_decode.sv
gem_hits_ram.sv
gem_capture_ctrl.sv
gem_readout.sv
gem_top.sv
tb_gem.sv
